// File: hdl/dnc_settings.svh
//////////////////////////////
// Sizes and fixed-point format of the DNC addressing slice.
// Index ports are 2 bits wide, so N and W must stay at 4 or less.
//////////////////////////////

`ifndef DNC_SETTINGS_SVH
`define DNC_SETTINGS_SVH

// Memory locations and words per location
`define DNC_N 4
`define DNC_W 4

// Signed Q8.8
`define DNC_DATA_BITS 16
`define DNC_FRAC_BITS 8
`define DNC_ONE 16'h0100

`endif

// File: hdl/dnc_pkg.sv
//////////////////////////////
// Shared types of the DNC slice. All values are signed Q8.8.
// Products are truncated and sums wrap at 16 bits.
//////////////////////////////

`include "dnc_settings.svh"

package dnc_pkg;

  typedef logic signed [`DNC_DATA_BITS-1:0] fx_t;

  // One value per memory location (w, wr, p)
  typedef fx_t [`DNC_N-1:0] loc_vec_t;
  // One value per word (e, v, r, one row of M)
  typedef fx_t [`DNC_W-1:0] word_vec_t;

  typedef enum logic [1:0] {VEC_W, VEC_E, VEC_V, VEC_WR} vec_sel_e;

  typedef enum logic {OUT_P, OUT_R} out_sel_e;

  typedef enum logic [1:0] {ST_IDLE, ST_PRECEDENCE, ST_MEMORY, ST_READ} ctrl_state_e;

  // Full product, arithmetic shift, keep low 16 bits
  function automatic fx_t fx_mul(input fx_t a, input fx_t b);
    logic signed [2*`DNC_DATA_BITS-1:0] prod;
    prod = a * b;
    return fx_t'(prod >>> `DNC_FRAC_BITS);
  endfunction

endpackage

// File: hdl/dnc_vec_if.sv
//////////////////////////////
// Loaded vectors from the bank to the compute units.
// Contents only change while the controller is idle.
//////////////////////////////

interface dnc_vec_if;

  // Write and read weightings
  dnc_pkg::loc_vec_t  w;
  dnc_pkg::loc_vec_t  wr;

  // Erase and write vectors
  dnc_pkg::word_vec_t e;
  dnc_pkg::word_vec_t v;

  modport bank (
    output w, wr, e, v
  );

  modport unit (
    input w, wr, e, v
  );

endinterface

// File: hdl/dnc_vector_bank.sv
//////////////////////////////
// Holds w, e, v and wr, one element written per load.
// Loads while busy are ignored so the units see stable vectors.
//////////////////////////////

module dnc_vector_bank (
  input  logic              CLK,
  input  logic              RST,
  input  logic              ready,
  input  logic              load_valid,
  input  dnc_pkg::vec_sel_e load_sel,
  input  logic [1:0]        load_index,
  input  dnc_pkg::fx_t      load_data,
  dnc_vec_if.bank           vec
);

  dnc_pkg::loc_vec_t  w_q;
  dnc_pkg::loc_vec_t  wr_q;
  dnc_pkg::word_vec_t e_q;
  dnc_pkg::word_vec_t v_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_q  <= '0;
      wr_q <= '0;
      e_q  <= '0;
      v_q  <= '0;
    end else if (load_valid && ready) begin
      case (load_sel)
        dnc_pkg::VEC_W:  w_q[load_index]  <= load_data;
        dnc_pkg::VEC_E:  e_q[load_index]  <= load_data;
        dnc_pkg::VEC_V:  v_q[load_index]  <= load_data;
        dnc_pkg::VEC_WR: wr_q[load_index] <= load_data;
        default: begin
        end
      endcase
    end
  end

  assign vec.w  = w_q;
  assign vec.wr = wr_q;
  assign vec.e  = e_q;
  assign vec.v  = v_q;

endmodule

// File: hdl/dnc_controller.sv
//////////////////////////////
// Start/ready FSM: precedence, memory, then read.
// ready is high only in ST_IDLE; a start elsewhere is dropped.
//////////////////////////////

module dnc_controller (
  input  logic CLK,
  input  logic RST,
  input  logic start,
  output logic ready,
  output logic prec_start,
  output logic mem_start,
  output logic read_start,
  input  logic prec_done,
  input  logic mem_done,
  input  logic read_done
);

  dnc_pkg::ctrl_state_e state;

  // Idle also gates the load port
  assign ready = (state == dnc_pkg::ST_IDLE);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= dnc_pkg::ST_IDLE;
      prec_start <= 1'b0;
      mem_start  <= 1'b0;
      read_start <= 1'b0;
    end else begin
      // Step starts are single-cycle pulses
      prec_start <= 1'b0;
      mem_start  <= 1'b0;
      read_start <= 1'b0;

      case (state)
        dnc_pkg::ST_IDLE: begin
          if (start) begin
            state      <= dnc_pkg::ST_PRECEDENCE;
            prec_start <= 1'b1;
          end
        end

        dnc_pkg::ST_PRECEDENCE: begin
          if (prec_done) begin
            state     <= dnc_pkg::ST_MEMORY;
            mem_start <= 1'b1;
          end
        end

        // Read must see the fully updated M
        dnc_pkg::ST_MEMORY: begin
          if (mem_done) begin
            state      <= dnc_pkg::ST_READ;
            read_start <= 1'b1;
          end
        end

        dnc_pkg::ST_READ: begin
          if (read_done) begin
            state <= dnc_pkg::ST_IDLE;
          end
        end

        default: begin
          state <= dnc_pkg::ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: hdl/dnc_precedence_weighting.sv
//////////////////////////////
// Precedence vector p, updated for all j in one cycle.
// p persists across runs; only reset clears it.
//////////////////////////////

`include "dnc_settings.svh"

module dnc_precedence_weighting (
  input  logic              CLK,
  input  logic              RST,
  input  logic              step_start,
  output logic              step_done,
  dnc_vec_if.unit           vec,
  output dnc_pkg::loc_vec_t p
);

  dnc_pkg::fx_t w_sum;
  dnc_pkg::fx_t w_rest;

  // Sum of w and one minus it, both wrapping at 16 bits
  always_comb begin
    w_sum = '0;
    for (int i = 0; i < `DNC_N; i++) begin
      w_sum = w_sum + vec.w[i];
    end
    w_rest = dnc_pkg::fx_t'(`DNC_ONE) - w_sum;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      p         <= '0;
      step_done <= 1'b0;
    end else begin
      step_done <= step_start;
      if (step_start) begin
        for (int j = 0; j < `DNC_N; j++) begin
          p[j] <= dnc_pkg::fx_mul(w_rest, p[j]) + vec.w[j];
        end
      end
    end
  end

endmodule

// File: hdl/dnc_memory_matrix.sv
//////////////////////////////
// Memory M, one element erased and written per cycle.
// A step takes N*W cycles, walking k fastest.
// row_data is combinational for the read unit.
//////////////////////////////

`include "dnc_settings.svh"

module dnc_memory_matrix (
  input  logic               CLK,
  input  logic               RST,
  input  logic               step_start,
  output logic               step_done,
  dnc_vec_if.unit            vec,
  input  logic [1:0]         row_index,
  output dnc_pkg::word_vec_t row_data
);

  localparam logic [1:0] J_LAST = 2'(`DNC_N - 1);
  localparam logic [1:0] K_LAST = 2'(`DNC_W - 1);

  dnc_pkg::word_vec_t m [`DNC_N];

  logic         busy;
  logic [1:0]   j_cnt;
  logic [1:0]   k_cnt;
  dnc_pkg::fx_t erase_keep;
  dnc_pkg::fx_t add_term;
  dnc_pkg::fx_t m_next;

  // M(j,k) * (1 - w(j)e(k)) + w(j)v(k)
  always_comb begin
    erase_keep = dnc_pkg::fx_t'(`DNC_ONE) - dnc_pkg::fx_mul(vec.w[j_cnt], vec.e[k_cnt]);
    add_term   = dnc_pkg::fx_mul(vec.w[j_cnt], vec.v[k_cnt]);
    m_next     = dnc_pkg::fx_mul(m[j_cnt][k_cnt], erase_keep) + add_term;
  end

  // High while the last element is written
  assign step_done = busy && (j_cnt == J_LAST) && (k_cnt == K_LAST);

  assign row_data = m[row_index];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      j_cnt <= '0;
      k_cnt <= '0;
      for (int j = 0; j < `DNC_N; j++) begin
        m[j] <= '0;
      end
    end else if (step_start) begin
      busy  <= 1'b1;
      j_cnt <= '0;
      k_cnt <= '0;
    end else if (busy) begin
      m[j_cnt][k_cnt] <= m_next;
      if (k_cnt == K_LAST) begin
        k_cnt <= '0;
        j_cnt <= j_cnt + 2'd1;
        if (j_cnt == J_LAST) begin
          busy <= 1'b0;
        end
      end else begin
        k_cnt <= k_cnt + 2'd1;
      end
    end
  end

endmodule

// File: hdl/dnc_read_vectors.sv
//////////////////////////////
// Read vector r, one memory row per cycle.
// r only changes at the end of a step.
//////////////////////////////

`include "dnc_settings.svh"

module dnc_read_vectors (
  input  logic               CLK,
  input  logic               RST,
  input  logic               step_start,
  output logic               step_done,
  dnc_vec_if.unit            vec,
  output logic [1:0]         row_index,
  input  dnc_pkg::word_vec_t row_data,
  output dnc_pkg::word_vec_t r
);

  localparam logic [1:0] J_LAST = 2'(`DNC_N - 1);

  logic               busy;
  dnc_pkg::word_vec_t acc;
  dnc_pkg::word_vec_t acc_next;

  // Add wr(j) times row j to every word at once
  always_comb begin
    for (int k = 0; k < `DNC_W; k++) begin
      acc_next[k] = acc[k] + dnc_pkg::fx_mul(row_data[k], vec.wr[row_index]);
    end
  end

  assign step_done = busy && (row_index == J_LAST);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      row_index <= '0;
      acc       <= '0;
      r         <= '0;
    end else if (step_start) begin
      busy      <= 1'b1;
      row_index <= '0;
      acc       <= '0;
    end else if (busy) begin
      acc       <= acc_next;
      row_index <= row_index + 2'd1;
      // Last row completes r
      if (row_index == J_LAST) begin
        busy <= 1'b0;
        r    <= acc_next;
      end
    end
  end

endmodule

// File: hdl/dnc_addressing.sv
//////////////////////////////
// Addressing slice with one write head and one read head.
// Loads and starts are taken only while ready is high.
// out_data is combinational from out_sel and out_index.
//////////////////////////////

module dnc_addressing (
  input  logic                CLK,
  input  logic                RST,
  input  logic                load_valid,
  input  dnc_pkg::vec_sel_e   load_sel,
  input  logic [1:0]          load_index,
  input  dnc_pkg::fx_t        load_data,
  input  logic                start,
  output logic                ready,
  input  dnc_pkg::out_sel_e   out_sel,
  input  logic [1:0]          out_index,
  output dnc_pkg::fx_t        out_data
);

  logic prec_start;
  logic prec_done;
  logic mem_start;
  logic mem_done;
  logic read_start;
  logic read_done;

  logic [1:0]         row_index;
  dnc_pkg::word_vec_t row_data;
  dnc_pkg::loc_vec_t  p;
  dnc_pkg::word_vec_t r;

  dnc_vec_if vec_bus ();

  //////////////////////////////
  // Load side and sequencing
  //////////////////////////////

  dnc_vector_bank bank_i (
    .CLK        (CLK),
    .RST        (RST),
    .ready      (ready),
    .load_valid (load_valid),
    .load_sel   (load_sel),
    .load_index (load_index),
    .load_data  (load_data),
    .vec        (vec_bus.bank)
  );

  dnc_controller ctrl_i (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .ready      (ready),
    .prec_start (prec_start),
    .mem_start  (mem_start),
    .read_start (read_start),
    .prec_done  (prec_done),
    .mem_done   (mem_done),
    .read_done  (read_done)
  );

  //////////////////////////////
  // Compute units
  //////////////////////////////

  dnc_precedence_weighting prec_i (
    .CLK        (CLK),
    .RST        (RST),
    .step_start (prec_start),
    .step_done  (prec_done),
    .vec        (vec_bus.unit),
    .p          (p)
  );

  dnc_memory_matrix mem_i (
    .CLK        (CLK),
    .RST        (RST),
    .step_start (mem_start),
    .step_done  (mem_done),
    .vec        (vec_bus.unit),
    .row_index  (row_index),
    .row_data   (row_data)
  );

  dnc_read_vectors read_i (
    .CLK        (CLK),
    .RST        (RST),
    .step_start (read_start),
    .step_done  (read_done),
    .vec        (vec_bus.unit),
    .row_index  (row_index),
    .row_data   (row_data),
    .r          (r)
  );

  // Read-back of p or r
  always_comb begin
    case (out_sel)
      dnc_pkg::OUT_P: out_data = p[out_index];
      default:        out_data = r[out_index];
    endcase
  end

endmodule

// File: dv/dnc_addressing_properties.sv
//////////////////////////////
// Handshake and read-back checks, bound into dnc_addressing.
// A run must finish within 40 cycles at the default sizes.
//////////////////////////////

module dnc_addressing_properties (
  input logic         CLK,
  input logic         RST,
  input logic         start,
  input logic         ready,
  input dnc_pkg::fx_t out_data
);

  logic        rst_q;
  int unsigned low_cnt;

  // Reset delayed by one edge, and cycles spent busy
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      rst_q   <= 1'b1;
      low_cnt <= 0;
    end else begin
      rst_q   <= 1'b0;
      low_cnt <= ready ? 0 : low_cnt + 1;
    end
  end

  ready_after_reset: assert property (@(posedge CLK) (rst_q && !RST) |-> ready)
    else $error("ready low in the first cycle after reset");

  start_drops_ready: assert property (@(posedge CLK) disable iff (RST) (start && ready) |=> !ready)
    else $error("ready still high after an accepted start");

  run_finishes: assert property (@(posedge CLK) disable iff (RST) low_cnt <= 40)
    else $error("ready low for more than 40 cycles");

  out_data_known: assert property (@(posedge CLK) disable iff (RST) !$isunknown(out_data))
    else $error("out_data unknown");

endmodule

bind dnc_addressing dnc_addressing_properties props_i (
  .CLK      (CLK),
  .RST      (RST),
  .start    (start),
  .ready    (ready),
  .out_data (out_data)
);

// File: dv/dnc_addressing_tb.sv
//////////////////////////////
// Testbench for the DNC addressing slice with its own Q8.8 model.
// Checks are immediate assertions on out_data after each run.
// Model vectors hold only loads made while ready was high.
//////////////////////////////

`include "dnc_settings.svh"

module dnc_addressing_tb;

  localparam int MAX_CYCLES = 3000;

  logic              CLK;
  logic              RST;
  logic              load_valid;
  dnc_pkg::vec_sel_e load_sel;
  logic [1:0]        load_index;
  dnc_pkg::fx_t      load_data;
  logic              start;
  logic              ready;
  dnc_pkg::out_sel_e out_sel;
  logic [1:0]        out_index;
  dnc_pkg::fx_t      out_data;

  // Reference model state
  logic [15:0] w_m [`DNC_N];
  logic [15:0] wr_m [`DNC_N];
  logic [15:0] p_m [`DNC_N];
  logic [15:0] e_m [`DNC_W];
  logic [15:0] v_m [`DNC_W];
  logic [15:0] r_m [`DNC_W];
  logic [15:0] mem_m [`DNC_N][`DNC_W];

  int seed = 32'hcc246c46;
  int cycles;
  int test_errors;
  int tests_run;
  int tests_failed;

  dnc_addressing dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // 11 runs of about 60 cycles with loads and read-back, plus margin
  always @(posedge CLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Model
  //////////////////////////////

  // Truncating Q8.8 product
  function automatic logic [15:0] qmul(input logic [15:0] a, input logic [15:0] b);
    int prod;
    prod = int'($signed(a)) * int'($signed(b));
    return prod[23:8];
  endfunction

  function automatic void model_step();
    logic [15:0] w_sum;
    logic [15:0] rest;
    logic [15:0] acc;
    w_sum = '0;
    for (int i = 0; i < `DNC_N; i++) w_sum = w_sum + w_m[i];
    rest = `DNC_ONE - w_sum;
    for (int j = 0; j < `DNC_N; j++) p_m[j] = qmul(rest, p_m[j]) + w_m[j];
    for (int j = 0; j < `DNC_N; j++) begin
      for (int k = 0; k < `DNC_W; k++) begin
        mem_m[j][k] = qmul(mem_m[j][k], `DNC_ONE - qmul(w_m[j], e_m[k])) + qmul(w_m[j], v_m[k]);
      end
    end
    // Read uses the updated memory
    for (int k = 0; k < `DNC_W; k++) begin
      acc = '0;
      for (int j = 0; j < `DNC_N; j++) acc = acc + qmul(mem_m[j][k], wr_m[j]);
      r_m[k] = acc;
    end
  endfunction

  // Range -1.0 to 1.0
  function automatic logic [15:0] rand_small();
    return 16'($random(seed) % 257);
  endfunction

  function automatic void randomize_vectors();
    for (int i = 0; i < 4; i++) begin
      w_m[i]  = rand_small();
      e_m[i]  = rand_small();
      v_m[i]  = rand_small();
      wr_m[i] = rand_small();
    end
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic load_all();
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < 4; i++) begin
        @(posedge CLK);
        load_valid <= 1'b1;
        load_sel   <= dnc_pkg::vec_sel_e'(2'(s));
        load_index <= 2'(i);
        case (s)
          0: load_data <= w_m[i];
          1: load_data <= e_m[i];
          2: load_data <= v_m[i];
          default: load_data <= wr_m[i];
        endcase
      end
    end
    @(posedge CLK);
    load_valid <= 1'b0;
  endtask

  task automatic start_run(input bit noisy);
    @(posedge CLK);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
    if (noisy) begin
      // Junk loads and starts while busy
      repeat (5) begin
        @(posedge CLK);
        load_valid <= 1'b1;
        load_sel   <= dnc_pkg::vec_sel_e'(2'($random(seed)));
        load_index <= 2'($random(seed));
        load_data  <= 16'($random(seed));
        start      <= 1'b1;
      end
      @(posedge CLK);
      load_valid <= 1'b0;
      start      <= 1'b0;
    end
    @(negedge CLK);
    while (!ready) @(negedge CLK);
    model_step();
  endtask

  task automatic read_back(input bit sel_r, input int idx, output logic [15:0] value);
    @(posedge CLK);
    out_sel   <= sel_r ? dnc_pkg::OUT_R : dnc_pkg::OUT_P;
    out_index <= 2'(idx);
    @(negedge CLK);
    value = out_data;
  endtask

  task automatic check_outputs();
    logic [15:0] got;
    logic [15:0] exp;
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 4; i++) begin
        read_back(s[0], i, got);
        exp = s[0] ? r_m[i] : p_m[i];
        assert (got === exp) else begin
          $display("ERR out_data %s[%0d] expected %h got %h", s[0] ? "r" : "p", i, exp, got);
          test_errors++;
        end
      end
    end
  endtask

  // r against v directly, or against zero
  task automatic check_read_vector(input bit expect_zero);
    logic [15:0] got;
    logic [15:0] exp;
    for (int k = 0; k < `DNC_W; k++) begin
      read_back(1'b1, k, got);
      exp = expect_zero ? 16'h0000 : v_m[k];
      assert (got === exp) else begin
        $display("ERR out_data r[%0d] expected %h got %h", k, exp, got);
        test_errors++;
      end
    end
  endtask

  function automatic void finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      $display("test %0d %s: fail with %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endfunction

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    RST        = 1'b1;
    load_valid = 1'b0;
    load_sel   = dnc_pkg::VEC_W;
    load_index = '0;
    load_data  = '0;
    start      = 1'b0;
    out_sel    = dnc_pkg::OUT_P;
    out_index  = '0;
    for (int i = 0; i < 4; i++) begin
      w_m[i]  = '0;
      e_m[i]  = '0;
      v_m[i]  = '0;
      wr_m[i] = '0;
      p_m[i]  = '0;
      r_m[i]  = '0;
      for (int k = 0; k < 4; k++) mem_m[i][k] = '0;
    end
    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    @(negedge CLK);
    assert (ready === 1'b1) else begin
      $display("ERR ready expected 1 got %h", ready);
      test_errors++;
    end
    check_outputs();
    finish_test("reset state");

    // 0.25 at location 1, two runs show p persists
    w_m[1] = 16'h0040;
    load_all();
    start_run(1'b0);
    check_outputs();
    start_run(1'b0);
    check_outputs();
    finish_test("precedence");

    for (int i = 0; i < 4; i++) begin
      w_m[i]  = (i == 2) ? `DNC_ONE : 16'h0000;
      wr_m[i] = w_m[i];
      e_m[i]  = '0;
      v_m[i]  = rand_small();
    end
    load_all();
    start_run(1'b0);
    check_outputs();
    check_read_vector(1'b0);
    finish_test("memory write");

    for (int i = 0; i < 4; i++) begin
      e_m[i] = `DNC_ONE;
      v_m[i] = '0;
    end
    load_all();
    start_run(1'b0);
    check_outputs();
    check_read_vector(1'b1);
    finish_test("memory erase");

    randomize_vectors();
    load_all();
    start_run(1'b1);
    check_outputs();
    finish_test("busy inputs");

    repeat (6) begin
      randomize_vectors();
      load_all();
      start_run(1'b0);
      check_outputs();
    end
    finish_test("random runs");

    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: dnc_addressing.f
+incdir+hdl
hdl/dnc_pkg.sv
hdl/dnc_vec_if.sv
hdl/dnc_vector_bank.sv
hdl/dnc_controller.sv
hdl/dnc_precedence_weighting.sv
hdl/dnc_memory_matrix.sv
hdl/dnc_read_vectors.sv
hdl/dnc_addressing.sv
dv/dnc_addressing_properties.sv
dv/dnc_addressing_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DNC addressing testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f dnc_addressing.f \
  --top-module dnc_addressing_tb \
  -Mdir obj_dir

./obj_dir/Vdnc_addressing_tb > sim.log 2>&1 || true
cat sim.log

grep -q "ALL TESTS PASSED" sim.log
